/* mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// bit positions inside the one-hot alu op.
`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_SLT  2
`define ALU_SLTU 3
`define ALU_SLL  4
`define ALU_SRL  5
`define ALU_SRA  6
`define ALU_LUI  7
`define ALU_AND  8
`define ALU_OR   9
`define ALU_XOR  10
`define ALU_NOR  11
`define ALU_OP_W 12

// register file geometry.
`define REG_ADDR_W 5
`define XLEN       32

`endif

/* mips_isa_pkg.sv */
`include "mips_macros.svh"

package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_COP0    = 6'h10, OP_SPECIAL2 = 6'h1c,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LWL   = 6'h22, OP_LW    = 6'h23,
        OP_LBU     = 6'h24, OP_LHU    = 6'h25, OP_LWR   = 6'h26,
        OP_SB      = 6'h28, OP_SH     = 6'h29, OP_SWL   = 6'h2a, OP_SW    = 6'h2b,
        OP_SWR     = 6'h2e
    } opcode_t;

    typedef enum logic [5:0] {
        F_SLL   = 6'h00, F_SRL   = 6'h02, F_SRA    = 6'h03, F_SLLV  = 6'h04,
        F_SRLV  = 6'h06, F_SRAV  = 6'h07, F_JR     = 6'h08, F_JALR  = 6'h09,
        F_SYSCALL = 6'h0c, F_BREAK = 6'h0d,
        F_MFHI  = 6'h10, F_MTHI  = 6'h11, F_MFLO   = 6'h12, F_MTLO  = 6'h13,
        F_MULT  = 6'h18, F_MULTU = 6'h19, F_DIV    = 6'h1a, F_DIVU  = 6'h1b,
        F_ADD   = 6'h20, F_ADDU  = 6'h21, F_SUB    = 6'h22, F_SUBU  = 6'h23,
        F_AND   = 6'h24, F_OR    = 6'h25, F_XOR    = 6'h26, F_NOR   = 6'h27,
        F_SLT   = 6'h2a, F_SLTU  = 6'h2b
    } func_t;

    // regimm branches are told apart by rt.
    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

    localparam logic [4:0] RS_MFC0 = 5'h00;
    localparam logic [4:0] RS_MTC0 = 5'h04;
    localparam logic [5:0] F2_MUL   = 6'h02; // special2 func.
    localparam logic [5:0] CO_TLBR  = 6'h01;
    localparam logic [5:0] CO_TLBWI = 6'h02;
    localparam logic [5:0] CO_TLBP  = 6'h08;
    localparam logic [5:0] CO_ERET  = 6'h18;

    typedef struct packed {
        opcode_t                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        func_t                  func;
    } instr_t;

endpackage

/* mips_ctrl_pkg.sv */
`include "mips_macros.svh"

package mips_ctrl_pkg;

    typedef struct packed {
        logic a_is_pc;
        logic a_is_rs_data;
        logic a_is_shamt;
        logic b_is_rt_data;
        logic b_is_imm;
        logic b_is_8;
    } alu_sel_t;

    typedef struct packed {
        logic alu;
        logic lo;
        logic hi;
        logic product;
    } result_sel_t;

    typedef struct packed {
        logic w;
        logic b;
        logic h;
        logic bu;
        logic hu;
        logic wl;
        logic wr;
        logic en;
        logic wen;
    } mem_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic addr_is_rd;
        logic addr_is_rt;
        logic addr_is_31;
        logic is_alu;
        logic is_mem;
    } wb_ctrl_t;

    typedef struct packed {
        logic mult;
        logic multu;
        logic div;
        logic divu;
        logic lo_wen;
        logic hi_wen;
    } muldiv_ctrl_t;

    typedef struct packed {
        logic syscall;
        logic reserved;
        logic brk;
        logic eret;
        logic tlbp;
        logic tlbwi;
        logic tlbr;
        logic mtc0;
        logic mfc0;
    } exc_ctrl_t;

    // one-hot redirect to fetch.
    typedef struct packed {
        logic next;
        logic branch_target;
        logic jal_target;
        logic jr_target;
    } pc_sel_t;

    typedef struct packed {
        logic [`ALU_OP_W-1:0] alu_op;
        alu_sel_t             alu_sel;
        logic                 imm_sign_ext;
        logic                 overflow_en;
        result_sel_t          result_sel;
        mem_ctrl_t            mem;
        wb_ctrl_t             wb;
        muldiv_ctrl_t         muldiv;
        exc_ctrl_t            exc;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t             ctrl;
        logic [`XLEN-1:0]     rs_data;
        logic [`XLEN-1:0]     rt_data;
        mips_isa_pkg::instr_t instr;
    } id_ex_t;

endpackage

/* pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data; // idle cycles hold the last payload.
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid))
        else $error("pipe_reg valid unknown after reset");

endmodule

/* mips_regfile.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic [`REG_ADDR_W-1:0] rt_addr,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       wr_data,
    output logic [`XLEN-1:0]       rs_data,
    output logic [`XLEN-1:0]       rt_data
);

    logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W)-1]; // $zero is not stored.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no bypass of a same-cycle write.
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    // a write is read back in the next cycle and $zero keeps reading zero.
    a_write_read_back: assert property (@(posedge clk) disable iff (reset)
        wr_en |=> (rs_addr != $past(wr_addr))
                  || (rs_data == (($past(wr_addr) == '0) ? '0 : $past(wr_data))))
        else $error("register file read back wrong data");

endmodule

/* branch_ctrl.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module branch_ctrl (
    input  logic                    en,
    input  mips_isa_pkg::opcode_t   op,
    input  logic [`REG_ADDR_W-1:0]  rt,
    input  logic [`XLEN-1:0]        rs_data,
    input  logic [`XLEN-1:0]        rt_data,
    output logic                    is_branch,
    output logic                    take,
    output logic                    link
);
    import mips_isa_pkg::*;

    logic regimm;
    logic is_beq, is_bne, is_blez, is_bgtz;
    logic is_bltz, is_bgez, is_bltzal, is_bgezal;
    logic rs_eq_rt, rs_neg, rs_zero;

    assign regimm    = op == OP_REGIMM;
    assign is_beq    = op == OP_BEQ;
    assign is_bne    = op == OP_BNE;
    assign is_blez   = op == OP_BLEZ;
    assign is_bgtz   = op == OP_BGTZ;
    assign is_bltz   = regimm & (rt == RT_BLTZ);
    assign is_bgez   = regimm & (rt == RT_BGEZ);
    assign is_bltzal = regimm & (rt == RT_BLTZAL);
    assign is_bgezal = regimm & (rt == RT_BGEZAL);

    assign rs_eq_rt = rs_data == rt_data;
    assign rs_neg   = rs_data[`XLEN-1]; // signed compare against zero.
    assign rs_zero  = rs_data == '0;

    assign is_branch = |{is_beq, is_bne, is_blez, is_bgtz,
                         is_bltz, is_bgez, is_bltzal, is_bgezal};
    assign take = en & ((is_beq & rs_eq_rt) | (is_bne & ~rs_eq_rt)
                      | (is_blez & (rs_neg | rs_zero))
                      | (is_bgtz & ~rs_neg & ~rs_zero)
                      | ((is_bltz | is_bltzal) & rs_neg)
                      | ((is_bgez | is_bgezal) & ~rs_neg));
    assign link = is_bltzal | is_bgezal; // links whether taken or not.

endmodule

/* decode_control.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module decode_control (
    input  logic                    valid,
    input  mips_isa_pkg::instr_t    instr,
    input  logic [`XLEN-1:0]        rs_data,
    input  logic [`XLEN-1:0]        rt_data,
    output mips_ctrl_pkg::id_ctrl_t ctrl,
    output mips_ctrl_pkg::pc_sel_t  pc_sel,
    output logic                    branch_or_jump
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    opcode_t op;
    func_t   fn;
    logic    r_type, cop0, cop0_co, mfc0;
    logic    is_j, is_jal, is_jr, is_jalr, is_mul;
    logic    is_load, is_store, logic_imm, imm_arith, shift_const;
    logic    link, link_31, known_op;
    logic    br_is_branch, br_take, br_link;

    assign op          = instr.op;
    assign fn          = instr.func;
    assign r_type      = op == OP_SPECIAL;
    assign cop0        = op == OP_COP0;
    assign cop0_co     = cop0 & instr.rs[4]; // func selects the op in the co form.
    assign mfc0        = cop0 & (instr.rs == RS_MFC0);
    assign is_j        = op == OP_J;
    assign is_jal      = op == OP_JAL;
    assign is_jr       = r_type & (fn == F_JR);
    assign is_jalr     = r_type & (fn == F_JALR);
    assign is_mul      = (op == OP_SPECIAL2) & (fn == F2_MUL);
    assign is_load     = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    assign is_store    = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    assign logic_imm   = op inside {OP_ANDI, OP_ORI, OP_XORI};
    assign imm_arith   = logic_imm | (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI});
    assign shift_const = r_type & (fn inside {F_SLL, F_SRL, F_SRA});
    assign link_31     = is_jal | br_link;
    assign link        = link_31 | is_jalr;
    assign known_op    = |{r_type, br_is_branch, cop0, is_mul, is_load, is_store,
                           imm_arith, is_j, is_jal};

    branch_ctrl u_branch (
        .en        (valid),
        .op        (op),
        .rt        (instr.rt),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .is_branch (br_is_branch),
        .take      (br_take),
        .link      (br_link)
    );

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[`ALU_ADD]  = (r_type & (fn inside {F_ADD, F_ADDU}))
                               | (op inside {OP_ADDI, OP_ADDIU}) | is_load | is_store | link;
        ctrl.alu_op[`ALU_SUB]  = r_type & (fn inside {F_SUB, F_SUBU});
        ctrl.alu_op[`ALU_SLT]  = (r_type & (fn == F_SLT)) | (op == OP_SLTI);
        ctrl.alu_op[`ALU_SLTU] = (r_type & (fn == F_SLTU)) | (op == OP_SLTIU);
        ctrl.alu_op[`ALU_SLL]  = r_type & (fn inside {F_SLL, F_SLLV});
        ctrl.alu_op[`ALU_SRL]  = r_type & (fn inside {F_SRL, F_SRLV});
        ctrl.alu_op[`ALU_SRA]  = r_type & (fn inside {F_SRA, F_SRAV});
        ctrl.alu_op[`ALU_LUI]  = op == OP_LUI;
        ctrl.alu_op[`ALU_AND]  = (r_type & (fn == F_AND)) | (op == OP_ANDI);
        ctrl.alu_op[`ALU_OR]   = (r_type & (fn == F_OR)) | (op == OP_ORI);
        ctrl.alu_op[`ALU_XOR]  = (r_type & (fn == F_XOR)) | (op == OP_XORI);
        ctrl.alu_op[`ALU_NOR]  = r_type & (fn == F_NOR);

        ctrl.alu_sel.a_is_pc      = link;
        ctrl.alu_sel.a_is_shamt   = shift_const;
        ctrl.alu_sel.a_is_rs_data = ~link & ~shift_const;
        ctrl.alu_sel.b_is_rt_data = r_type;
        ctrl.alu_sel.b_is_imm     = is_load | is_store | imm_arith;
        ctrl.alu_sel.b_is_8       = link; // return address is pc + 8.
        ctrl.imm_sign_ext         = ~logic_imm;
        ctrl.overflow_en          = (r_type & (fn inside {F_ADD, F_SUB})) | (op == OP_ADDI);

        ctrl.result_sel.hi      = r_type & (fn == F_MFHI);
        ctrl.result_sel.lo      = r_type & (fn == F_MFLO);
        ctrl.result_sel.product = is_mul;
        ctrl.result_sel.alu     = ~(ctrl.result_sel.hi | ctrl.result_sel.lo | is_mul);

        ctrl.mem.w   = op inside {OP_LW, OP_LWL, OP_LWR, OP_SW};
        ctrl.mem.b   = op inside {OP_LB, OP_SB};
        ctrl.mem.h   = op inside {OP_LH, OP_SH};
        ctrl.mem.bu  = op == OP_LBU;
        ctrl.mem.hu  = op == OP_LHU;
        ctrl.mem.wl  = op inside {OP_LWL, OP_SWL};
        ctrl.mem.wr  = op inside {OP_LWR, OP_SWR};
        ctrl.mem.en  = is_load;
        ctrl.mem.wen = is_store;

        ctrl.wb.reg_write  = |{r_type, is_load, link, imm_arith, mfc0, is_mul};
        ctrl.wb.addr_is_rd = r_type | is_mul;
        ctrl.wb.addr_is_31 = link_31;
        ctrl.wb.addr_is_rt = ~link_31 & ~(r_type | is_mul);
        ctrl.wb.is_mem     = is_load;
        ctrl.wb.is_alu     = ~is_load;

        ctrl.muldiv.mult   = (r_type & (fn == F_MULT)) | is_mul;
        ctrl.muldiv.multu  = r_type & (fn == F_MULTU);
        ctrl.muldiv.div    = r_type & (fn == F_DIV);
        ctrl.muldiv.divu   = r_type & (fn == F_DIVU);
        ctrl.muldiv.lo_wen = r_type & (fn == F_MTLO);
        ctrl.muldiv.hi_wen = r_type & (fn == F_MTHI);

        ctrl.exc.syscall  = r_type & (fn == F_SYSCALL);
        ctrl.exc.brk      = r_type & (fn == F_BREAK);
        ctrl.exc.reserved = ~known_op;
        ctrl.exc.eret     = cop0_co & (fn == CO_ERET);
        ctrl.exc.tlbp     = cop0_co & (fn == CO_TLBP);
        ctrl.exc.tlbwi    = cop0_co & (fn == CO_TLBWI);
        ctrl.exc.tlbr     = cop0_co & (fn == CO_TLBR);
        ctrl.exc.mtc0     = cop0 & (instr.rs == RS_MTC0);
        ctrl.exc.mfc0     = mfc0;
    end

    // jumps over jr/jalr over a taken branch.
    always_comb begin
        pc_sel = '0;
        if (valid && (is_j || is_jal)) begin
            pc_sel.jal_target = 1'b1;
        end else if (valid && (is_jr || is_jalr)) begin
            pc_sel.jr_target = 1'b1;
        end else if (br_take) begin
            pc_sel.branch_target = 1'b1;
        end else begin
            pc_sel.next = 1'b1;
        end
    end

    assign branch_or_jump = valid & (br_is_branch | is_j | is_jal | is_jr | is_jalr);

    always_comb begin
        a_redirect_flagged: assert (pc_sel.next || branch_or_jump)
            else $error("pc_sel redirect without branch_or_jump");
        if (valid) begin
            a_alu_op_onehot0: assert ($onehot0(ctrl.alu_op)) else $error("alu_op overlap");
            a_wb_addr_onehot: assert ($onehot({ctrl.wb.addr_is_rd, ctrl.wb.addr_is_rt,
                                               ctrl.wb.addr_is_31}))
                else $error("writeback address select not one-hot");
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_isa_pkg::instr_t    instr,
    input  logic                    instr_valid,
    input  logic                    wb_en,
    input  logic [`REG_ADDR_W-1:0]  wb_addr,
    input  logic [`XLEN-1:0]        wb_data,
    output mips_ctrl_pkg::pc_sel_t  pc_sel,
    output logic                    branch_or_jump,
    output mips_ctrl_pkg::id_ex_t   id_ex,
    output logic                    id_ex_valid
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    instr_t           if_id_instr;
    logic             if_id_valid;
    logic [`XLEN-1:0] rs_data;
    logic [`XLEN-1:0] rt_data;
    id_ctrl_t         id_ctrl;
    id_ex_t           id_ex_next;

    pipe_reg #(.payload_t(instr_t)) u_if_id (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (instr_valid),
        .in_data   (instr),
        .out_valid (if_id_valid),
        .out_data  (if_id_instr)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (if_id_instr.rs),
        .rt_addr (if_id_instr.rt),
        .wr_en   (wb_en),
        .wr_addr (wb_addr),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    decode_control u_decode (
        .valid          (if_id_valid),
        .instr          (if_id_instr),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .ctrl           (id_ctrl),
        .pc_sel         (pc_sel),
        .branch_or_jump (branch_or_jump)
    );

    assign id_ex_next = '{ctrl: id_ctrl, rs_data: rs_data, rt_data: rt_data, instr: if_id_instr};

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (if_id_valid),
        .in_data   (id_ex_next),
        .out_valid (id_ex_valid),
        .out_data  (id_ex)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* tb_decode_stage.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_decode_stage;
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    localparam int RESET_CYCLES = 10;

    // what one issued instruction should produce.
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] word;
        pc_sel_t          pc_sel;
        logic             bj;
        id_ctrl_t         ctrl;
        logic [`XLEN-1:0] rs_data;
        logic [`XLEN-1:0] rt_data;
    } expect_t;

    logic                   clk;
    logic                   reset;
    instr_t                 instr;
    logic                   instr_valid;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`XLEN-1:0]       wb_data;
    pc_sel_t                pc_sel;
    logic                   branch_or_jump;
    id_ex_t                 id_ex;
    logic                   id_ex_valid;

    logic [`XLEN-1:0] shadow [0:(1 << `REG_ADDR_W)-1]; // register model.
    expect_t          in_decode;
    expect_t          in_ex;
    pc_sel_t          idle_pc_sel;
    string            lines[$];
    int               error_count;
    int               watchdog_cycles;

    tb_clock_gen #(.PERIOD_NS(40)) u_clock_gen (.clk(clk));

    decode_stage u_decode_stage (
        .clk            (clk),
        .reset          (reset),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .pc_sel         (pc_sel),
        .branch_or_jump (branch_or_jump),
        .id_ex          (id_ex),
        .id_ex_valid    (id_ex_valid)
    );

    task automatic compare_ctrl(input string name, input id_ctrl_t got, input id_ctrl_t exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_pc_sel(input string name, input pc_sel_t got, input pc_sel_t exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_data(input string name, input logic [`XLEN-1:0] got,
                                input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic drive_inputs(input logic iv, input instr_t ins, input logic we,
                                input logic [`REG_ADDR_W-1:0] wa, input logic [`XLEN-1:0] wd);
        instr_valid = iv;
        instr       = ins;
        wb_en       = we;
        wb_addr     = wa;
        wb_data     = wd;
    endtask

    // advances one clock and checks decode and id/ex against what was issued.
    task automatic advance_cycle(input expect_t issued);
        @(posedge clk);
        #2;
        in_ex     = in_decode;
        in_decode = issued;
        if (in_decode.valid) begin
            compare_pc_sel("pc_sel", pc_sel, in_decode.pc_sel);
            compare_bit("branch_or_jump", branch_or_jump, in_decode.bj);
        end else begin
            compare_pc_sel("pc_sel", pc_sel, idle_pc_sel);
            compare_bit("branch_or_jump", branch_or_jump, 1'b0);
        end
        compare_bit("id_ex_valid", id_ex_valid, in_ex.valid);
        if (in_ex.valid) begin
            compare_ctrl("id_ex.ctrl", id_ex.ctrl, in_ex.ctrl);
            compare_data("id_ex.rs_data", id_ex.rs_data, in_ex.rs_data);
            compare_data("id_ex.rt_data", id_ex.rt_data, in_ex.rt_data);
            compare_data("id_ex.instr", id_ex.instr, in_ex.word);
        end
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int               fd;
        int               n;
        int               addr;
        int               gap;
        bit               after_write;
        string            line;
        expect_t          exp;
        expect_t          none;
        logic [`XLEN-1:0] data;
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] f [0:9];

        error_count = 0;
        after_write = 1'b0;
        none        = '0;
        in_decode   = '0;
        in_ex       = '0;
        idle_pc_sel      = '0;
        idle_pc_sel.next = 1'b1;
        foreach (shadow[i]) shadow[i] = '0;
        reset = 1'b1;
        drive_inputs(1'b0, '0, 1'b0, '0, '0);
        void'($urandom(36506));

        fd = $fopen("decode_patterns.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open decode_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && (line.getc(0) == "W" || line.getc(0) == "I")) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        watchdog_cycles = RESET_CYCLES + 5 * lines.size() + 5;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        compare_bit("id_ex_valid", id_ex_valid, 1'b0);
        compare_bit("branch_or_jump", branch_or_jump, 1'b0);
        compare_pc_sel("pc_sel", pc_sel, idle_pc_sel);

        foreach (lines[i]) begin
            if (lines[i].getc(0) == "W") begin
                n = $sscanf(lines[i], "W %d %h", addr, data);
                if (n != 2) begin
                    error_count++;
                    $display("pattern line %0d is malformed", i);
                end else begin
                    drive_inputs(1'b0, '0, 1'b1, addr[`REG_ADDR_W-1:0], data);
                    if (addr != 0) shadow[addr] = data; // $zero ignores writes.
                    advance_cycle(none);
                    after_write = 1'b1;
                end
            end else begin
                n = $sscanf(lines[i], "I %h %h %h %h %h %h %h %h %h %h %h", word,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                if (n != 11) begin
                    error_count++;
                    $display("pattern line %0d is malformed", i);
                end else begin
                    if (after_write) begin
                        drive_inputs(1'b0, '0, 1'b0, '0, '0);
                        advance_cycle(none); // write settles before the read.
                        after_write = 1'b0;
                    end
                    exp.valid   = 1'b1;
                    exp.word    = word;
                    exp.pc_sel  = pc_sel_t'(f[0][3:0]);
                    exp.bj      = f[1][0];
                    exp.ctrl    = id_ctrl_t'({f[2][11:0], f[3][5:0], f[4][1:0], f[5][3:0],
                                              f[6][8:0], f[7][5:0], f[8][5:0], f[9][8:0]});
                    exp.rs_data = shadow[word[25:21]];
                    exp.rt_data = shadow[word[20:16]];
                    drive_inputs(1'b1, instr_t'(word), 1'b0, '0, '0);
                    advance_cycle(exp);
                    gap = $urandom % 4;
                    if (exp.bj && gap == 0) begin
                        gap = 1; // an idle cycle after a redirect.
                    end
                    repeat (gap) begin
                        drive_inputs(1'b0, '0, 1'b0, '0, '0);
                        advance_cycle(none);
                    end
                end
            end
        end

        drive_inputs(1'b0, '0, 1'b0, '0, '0);
        advance_cycle(none);
        advance_cycle(none);

        $display("checks done, errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* decode_stage.f */
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
pipe_reg.sv
mips_regfile.sv
branch_ctrl.sv
decode_control.sv
decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_decode_stage \
    -f decode_stage.f -o tb_decode_stage_sim
./obj_dir/tb_decode_stage_sim | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* decode_patterns.txt */
# W reg data: register preload through the writeback port.
# I instr pc_sel bj alu_op alu_sel {sext,ovf} result mem wb muldiv exc, all hex.
I 00221820 8 0 001 14 3 8 000 32 00 000 # add, registers still zero
W 1 00000005
W 2 00000005
W 3 fffffff0
W 4 00000007
W 0 deadbeef
I 00812823 8 0 002 14 2 8 000 32 00 000 # subu
I 0061302a 8 0 004 14 2 8 000 32 00 000 # slt
I 000438c0 8 0 010 0c 2 8 000 32 00 000 # sll
I 3c081234 8 0 080 12 2 8 000 2a 00 000 # lui
I 3429ff00 8 0 200 12 0 8 000 2a 00 000 # ori
I 308a000f 8 0 100 12 0 8 000 2a 00 000 # andi
I 802b0004 8 0 001 12 2 8 082 29 00 000 # lb
I 944c0008 8 0 001 12 2 8 012 29 00 000 # lhu
I 886d0000 8 0 001 12 2 8 10a 29 00 000 # lwl
I ac24000c 8 0 001 12 2 8 101 0a 00 000 # sw
I b8820000 8 0 001 12 2 8 005 0a 00 000 # swr
I 10220004 4 1 000 10 2 8 000 0a 00 000 # beq taken
I 10240004 8 1 000 10 2 8 000 0a 00 000 # beq not taken
I 1c800008 4 1 000 10 2 8 000 0a 00 000 # bgtz taken
I 04700010 4 1 001 21 2 8 000 26 00 000 # bltzal taken
I 0c000100 2 1 001 21 2 8 000 26 00 000 # jal
I 08000040 2 1 000 10 2 8 000 0a 00 000 # j
I 00800008 1 1 000 14 2 8 000 32 00 000 # jr
I 0080f809 1 1 001 25 2 8 000 32 00 000 # jalr
I 00240018 8 0 000 14 2 8 000 32 20 000 # mult
I 0081001a 8 0 000 14 2 8 000 32 08 000 # div
I 00007010 8 0 000 14 2 2 000 32 00 000 # mfhi
I 00200013 8 0 000 14 2 8 000 32 02 000 # mtlo
I 70247802 8 0 000 10 2 1 000 32 20 000 # mul
I 40846000 8 0 000 10 2 8 000 0a 00 002 # mtc0
I 40106000 8 0 000 10 2 8 000 2a 00 001 # mfc0
I 42000018 8 0 000 10 2 8 000 0a 00 020 # eret
I 42000002 8 0 000 10 2 8 000 0a 00 008 # tlbwi
I 0000000c 8 0 000 14 2 8 000 32 00 100 # syscall
I 0000000d 8 0 000 14 2 8 000 32 00 040 # break
I fc000000 8 0 000 10 2 8 000 0a 00 080 # undefined opcode
